// File: nasti_sub.f
source/nasti_pkg.sv
source/arbiter_rr.sv
source/nasti_txn_table.sv
source/nasti_write_mux.sv
source/nasti_read_mux.sv
source/nasti_mem_target.sv
source/nasti_sub_top.sv
verif/nasti_sub_properties.sv
verif/nasti_sub_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the nasti subsystem testbench with Verilator and run it
# the simulator exit status gives pass or fail
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
   -Wno-fatal \
   --top-module nasti_sub_tb \
   -Mdir obj_dir \
   -f nasti_sub.f

./obj_dir/Vnasti_sub_tb

// File: verif/nasti_sub_tb.sv
//**********************************************************
// testbench for the four-port nasti subsystem
// per-port initiators, reference memory and response checks
//**********************************************************
module nasti_sub_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import nasti_pkg::*;

   localparam int test_cycles = 1000;             // worst case of all phases
   localparam int max_cycles  = 4 * test_cycles;

   logic clk = 1'b0;
   logic rstn;
   logic [n_ports-1:0][id_w-1:0]   aw_id, b_id, ar_id, r_id;
   logic [n_ports-1:0][addr_w-1:0] aw_addr, ar_addr;
   logic [n_ports-1:0][len_w-1:0]  aw_len, ar_len;
   logic [n_ports-1:0][data_w-1:0] w_data, r_data;
   logic [n_ports-1:0][strb_w-1:0] w_strb;
   logic [n_ports-1:0][1:0]        b_resp, r_resp;
   logic [n_ports-1:0] aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
   logic [n_ports-1:0] ar_valid, ar_ready, r_last, r_valid, r_ready;

   logic [data_w-1:0] ref_mem [64];
   logic [31:0]       rng = 32'h4ae6;
   bit                b_pend [n_ports];
   bit                r_pend [n_ports];
   int                exp_word [n_ports];
   int                exp_len [n_ports];
   int                beat_cnt [n_ports];
   int                cycles = 0;

   nasti_sub_top dut_i (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);   // xorshift32
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [data_w-1:0] ref_word(input int word);
      return ref_mem[word % 64];
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                             $time, name, got, exp));
   endtask

   task automatic ref_write(input int word, input logic [31:0] d, input logic [3:0] s);
      for (int b = 0; b < strb_w; b++)
         if (s[b])
            ref_mem[word][8*b +: 8] = d[8*b +: 8];
   endtask

   function automatic logic ready_roll(input bit bp);
      return bp ? (next_rand() % 4 != 0) : 1'b1;   // 3 of 4 cycles ready
   endfunction

   // burst inside the port's own quarter
   task automatic pick_burst(input int p, output int word, output int len);
      int off;
      len = int'(next_rand() % 4);
      off = int'(next_rand() % 16);
      if (off + len > 15)
         off = 15 - len;
      word = 16 * p + off;
   endtask

   task automatic do_write(input int p, input int word, input int len, input bit bp,
                           input bit full);
      logic [31:0] d;
      logic [3:0]  s;
      @(posedge clk);
      #1;
      aw_id[p]    = id_w'(p);
      aw_addr[p]  = addr_w'(word * 4);
      aw_len[p]   = len_w'(len);
      aw_valid[p] = 1'b1;
      b_pend[p]   = 1'b1;
      do @(posedge clk); while (!aw_ready[p]);
      #1;
      aw_valid[p] = 1'b0;
      for (int k = 0; k <= len; k++)
      begin
         d = next_rand();
         s = full ? 4'hf : 4'(next_rand());
         w_data[p]  = d;
         w_strb[p]  = s;
         w_last[p]  = (k == len);
         w_valid[p] = 1'b1;
         ref_write(word + k, d, s);
         do @(posedge clk); while (!w_ready[p]);
         #1;
      end
      w_valid[p] = 1'b0;
      w_last[p]  = 1'b0;
      while (b_pend[p])
      begin
         b_ready[p] = ready_roll(bp);
         @(posedge clk);
         #1;
      end
      b_ready[p] = 1'b0;
   endtask

   task automatic do_read(input int p, input int word, input int len, input bit bp);
      @(posedge clk);
      #1;
      ar_id[p]    = id_w'(p);
      ar_addr[p]  = addr_w'(word * 4);
      ar_len[p]   = len_w'(len);
      ar_valid[p] = 1'b1;
      exp_word[p] = word;
      exp_len[p]  = len;
      beat_cnt[p] = 0;
      r_pend[p]   = 1'b1;
      do @(posedge clk); while (!ar_ready[p]);
      #1;
      ar_valid[p] = 1'b0;
      while (r_pend[p])
      begin
         r_ready[p] = ready_roll(bp);
         @(posedge clk);
         #1;
      end
      r_ready[p] = 1'b0;
   endtask

   task automatic port_run(input int p);
      int word;
      int len;
      for (int k = 0; k < 4; k++)
         do_write(p, 16 * p + 4 * k, 3, 1'b0, 1'b1);   // define the whole quarter
      do_write(p, 16 * p + 1, 0, 1'b0, 1'b0);
      do_read(p, 16 * p + 1, 0, 1'b0);
      for (int k = 0; k < 8; k++)
      begin
         pick_burst(p, word, len);
         do_write(p, word, len, k >= 4, 1'b0);        // second half with back-pressure
         do_read(p, word, len, k >= 4);
      end
      for (int k = 0; k < 6; k++)
      begin
         pick_burst(p, word, len);
         if (p == 3 && k % 2 == 0)
            do_write(p, word, len, 1'b0, 1'b0);
         else
            do_read(p, word, len, 1'b0);
      end
   endtask

   // every response beat against the expected port, id and data
   always @(posedge clk)
   begin
      for (int p = 0; p < n_ports; p++)
      begin
         if (b_valid[p] && !b_pend[p])
            abort_run($sformatf("B response on port %0d with no write outstanding", p));
         if (r_valid[p] && !r_pend[p])
            abort_run($sformatf("R beat on port %0d with no read outstanding", p));
         if (b_valid[p] && b_ready[p])
         begin
            check($sformatf("b_id[%0d]", p), 32'(b_id[p]), 32'(p));
            check($sformatf("b_resp[%0d]", p), 32'(b_resp[p]), 32'(resp_okay));
            b_pend[p] = 1'b0;
         end
         if (r_valid[p] && r_ready[p])
         begin
            check($sformatf("r_id[%0d]", p), 32'(r_id[p]), 32'(p));
            check($sformatf("r_resp[%0d]", p), 32'(r_resp[p]), 32'(resp_okay));
            check($sformatf("r_data[%0d]", p), r_data[p],
                  ref_word(exp_word[p] + beat_cnt[p]));
            check($sformatf("r_last[%0d]", p), 32'(r_last[p]),
                  32'(beat_cnt[p] == exp_len[p]));
            beat_cnt[p]++;
            if (r_last[p])
               r_pend[p] = 1'b0;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= max_cycles)
         abort_run($sformatf("timeout, test not finished after %0d cycles", max_cycles));
   end

   initial
   begin
      rstn     = 1'b0;
      aw_id    = '0;
      aw_addr  = '0;
      aw_len   = '0;
      aw_valid = '0;
      w_data   = '0;
      w_strb   = '0;
      w_last   = '0;
      w_valid  = '0;
      b_ready  = '0;
      ar_id    = '0;
      ar_addr  = '0;
      ar_len   = '0;
      ar_valid = '0;
      r_ready  = '0;
      repeat (8) @(posedge clk);
      #1;
      rstn = 1'b1;
      for (int p = 0; p < n_ports; p++)
      begin
         do_write(p, 16 * p, 0, 1'b0, 1'b1);   // single beats, one port at a time
         do_read(p, 16 * p, 0, 1'b0);
      end
      fork
         port_run(0);
         port_run(1);
         port_run(2);
         port_run(3);
      join
      repeat (4) @(posedge clk);   // late stray responses still caught
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: verif/nasti_sub_properties.sv
//**********************************************************
// handshake and response routing checks on the nasti subsystem
//**********************************************************
module nasti_sub_properties
(
   input logic                          clk,
   input logic                          rstn,
   input logic                          t_aw_valid,
   input logic                          t_aw_ready,
   input logic                          t_w_valid,
   input logic                          t_ar_valid,
   input logic                          t_ar_ready,
   input logic                          t_b_valid,
   input logic                          t_b_ready,
   input logic                          t_r_valid,
   input logic                          t_r_ready,
   input logic [nasti_pkg::n_ports-1:0] b_valid,
   input logic [nasti_pkg::n_ports-1:0] r_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   // a raised valid stays up until its transfer
   aw_hold_a: assert property (@(posedge clk) disable iff (!rstn)
      t_aw_valid && !t_aw_ready |=> t_aw_valid)
      else $error("t_aw_valid dropped before t_aw_ready");
   ar_hold_a: assert property (@(posedge clk) disable iff (!rstn)
      t_ar_valid && !t_ar_ready |=> t_ar_valid)
      else $error("t_ar_valid dropped before t_ar_ready");
   b_hold_a: assert property (@(posedge clk) disable iff (!rstn)
      t_b_valid && !t_b_ready |=> t_b_valid)
      else $error("t_b_valid dropped before t_b_ready");
   r_hold_a: assert property (@(posedge clk) disable iff (!rstn)
      t_r_valid && !t_r_ready |=> t_r_valid)
      else $error("t_r_valid dropped before t_r_ready");

   // one owner per response beat
   b_route_a: assert property (@(posedge clk) disable iff (!rstn) $onehot0(b_valid))
      else $error("b_valid raised on more than one port");
   r_route_a: assert property (@(posedge clk) disable iff (!rstn) $onehot0(r_valid))
      else $error("r_valid raised on more than one port");

   aw_w_excl_a: assert property (@(posedge clk) disable iff (!rstn)
      !(t_aw_valid && t_w_valid))
      else $error("t_aw_valid and t_w_valid high together");

endmodule

bind nasti_sub_top nasti_sub_properties props_i
(
   .clk        (clk),
   .rstn       (rstn),
   .t_aw_valid (t_aw_valid),
   .t_aw_ready (t_aw_ready),
   .t_w_valid  (t_w_valid),
   .t_ar_valid (t_ar_valid),
   .t_ar_ready (t_ar_ready),
   .t_b_valid  (t_b_valid),
   .t_b_ready  (t_b_ready),
   .t_r_valid  (t_r_valid),
   .t_r_ready  (t_r_ready),
   .b_valid    (b_valid),
   .r_valid    (r_valid)
);

// File: source/nasti_sub_top.sv
//**********************************************************
// four-port nasti subsystem, muxes in front of one memory
//**********************************************************
module nasti_sub_top
(
   input  logic                                               clk,
   input  logic                                               rstn,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   aw_id,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::addr_w-1:0] aw_addr,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::len_w-1:0]  aw_len,
   input  logic [nasti_pkg::n_ports-1:0]                        aw_valid,
   output logic [nasti_pkg::n_ports-1:0]                        aw_ready,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::data_w-1:0] w_data,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::strb_w-1:0] w_strb,
   input  logic [nasti_pkg::n_ports-1:0]                        w_last,
   input  logic [nasti_pkg::n_ports-1:0]                        w_valid,
   output logic [nasti_pkg::n_ports-1:0]                        w_ready,
   output logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   b_id,
   output logic [nasti_pkg::n_ports-1:0][1:0]                   b_resp,
   output logic [nasti_pkg::n_ports-1:0]                        b_valid,
   input  logic [nasti_pkg::n_ports-1:0]                        b_ready,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   ar_id,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::addr_w-1:0] ar_addr,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::len_w-1:0]  ar_len,
   input  logic [nasti_pkg::n_ports-1:0]                        ar_valid,
   output logic [nasti_pkg::n_ports-1:0]                        ar_ready,
   output logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   r_id,
   output logic [nasti_pkg::n_ports-1:0][nasti_pkg::data_w-1:0] r_data,
   output logic [nasti_pkg::n_ports-1:0][1:0]                   r_resp,
   output logic [nasti_pkg::n_ports-1:0]                        r_last,
   output logic [nasti_pkg::n_ports-1:0]                        r_valid,
   input  logic [nasti_pkg::n_ports-1:0]                        r_ready
);
   import nasti_pkg::*;

   // target side
   logic [id_w-1:0]   t_aw_id;
   logic [addr_w-1:0] t_aw_addr;
   logic [len_w-1:0]  t_aw_len;
   logic              t_aw_valid;
   logic              t_aw_ready;
   logic [data_w-1:0] t_w_data;
   logic [strb_w-1:0] t_w_strb;
   logic              t_w_last;
   logic              t_w_valid;
   logic              t_w_ready;
   logic [id_w-1:0]   t_b_id;
   logic [1:0]        t_b_resp;
   logic              t_b_valid;
   logic              t_b_ready;
   logic [id_w-1:0]   t_ar_id;
   logic [addr_w-1:0] t_ar_addr;
   logic [len_w-1:0]  t_ar_len;
   logic              t_ar_valid;
   logic              t_ar_ready;
   logic [id_w-1:0]   t_r_id;
   logic [data_w-1:0] t_r_data;
   logic [1:0]        t_r_resp;
   logic              t_r_last;
   logic              t_r_valid;
   logic              t_r_ready;

   nasti_write_mux wr_mux_i (.*);

   nasti_read_mux rd_mux_i (.*);

   nasti_mem_target mem_i (.*);

endmodule

// File: source/nasti_mem_target.sv
//**********************************************************
// 64-word memory target, INCR bursts up to 4 beats
// one write engine and an in-order read queue
//**********************************************************
module nasti_mem_target
(
   input  logic                          clk,
   input  logic                          rstn,
   input  logic [nasti_pkg::id_w-1:0]    t_aw_id,
   input  logic [nasti_pkg::addr_w-1:0]  t_aw_addr,
   input  logic [nasti_pkg::len_w-1:0]   t_aw_len,
   input  logic                          t_aw_valid,
   output logic                          t_aw_ready,
   input  logic [nasti_pkg::data_w-1:0]  t_w_data,
   input  logic [nasti_pkg::strb_w-1:0]  t_w_strb,
   input  logic                          t_w_last,
   input  logic                          t_w_valid,
   output logic                          t_w_ready,
   output logic [nasti_pkg::id_w-1:0]    t_b_id,
   output logic [1:0]                    t_b_resp,
   output logic                          t_b_valid,
   input  logic                          t_b_ready,
   input  logic [nasti_pkg::id_w-1:0]    t_ar_id,
   input  logic [nasti_pkg::addr_w-1:0]  t_ar_addr,
   input  logic [nasti_pkg::len_w-1:0]   t_ar_len,
   input  logic                          t_ar_valid,
   output logic                          t_ar_ready,
   output logic [nasti_pkg::id_w-1:0]    t_r_id,
   output logic [nasti_pkg::data_w-1:0]  t_r_data,
   output logic [1:0]                    t_r_resp,
   output logic                          t_r_last,
   output logic                          t_r_valid,
   input  logic                          t_r_ready
);
   import nasti_pkg::*;

   logic [data_w-1:0] mem [2**(addr_w-2)];

   logic              w_busy;
   logic [addr_w-3:0] w_addr;   // word index
   logic [len_w-1:0]  w_left;
   logic [id_w-1:0]   w_id;
   logic              w_fire;
   logic              w_end;

   assign t_aw_ready = !w_busy && !t_b_valid;
   assign t_w_ready  = w_busy;
   assign t_b_id     = w_id;
   assign t_b_resp   = resp_okay;
   assign w_fire     = t_w_valid && t_w_ready;
   assign w_end      = t_w_last || (w_left == '0);   // last flag or beat count

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         w_busy    <= 1'b0;
         t_b_valid <= 1'b0;
      end
      else
      begin
         if (t_aw_valid && t_aw_ready)
            w_busy <= 1'b1;
         else if (w_fire && w_end)
         begin
            w_busy    <= 1'b0;
            t_b_valid <= 1'b1;
         end
         if (t_b_valid && t_b_ready)
            t_b_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (t_aw_valid && t_aw_ready)
      begin
         w_addr <= t_aw_addr[addr_w-1:2];
         w_left <= t_aw_len;
         w_id   <= t_aw_id;
      end
      else if (w_fire)
      begin
         for (int b = 0; b < strb_w; b++)
            if (t_w_strb[b])
               mem[w_addr][8*b +: 8] <= t_w_data[8*b +: 8];
         w_addr <= w_addr + 1'b1;
         w_left <= w_left - 1'b1;
      end
   end

   // read queue, head entry streams its beats
   logic [r_max-1:0][id_w-1:0]   q_id;
   logic [r_max-1:0][addr_w-3:0] q_addr;
   logic [r_max-1:0][len_w-1:0]  q_len;
   logic [$clog2(r_max)-1:0]     q_head;
   logic [$clog2(r_max)-1:0]     q_tail;
   logic [$clog2(r_max):0]       q_cnt;
   logic [len_w-1:0]             r_beat;
   logic                         ar_fire;
   logic                         r_pop;

   assign t_ar_ready = q_cnt < r_max;
   assign ar_fire    = t_ar_valid && t_ar_ready;
   assign t_r_valid  = q_cnt != '0;
   assign t_r_id     = q_id[q_head];
   assign t_r_data   = mem[q_addr[q_head] + (addr_w-2)'(r_beat)];
   assign t_r_resp   = resp_okay;
   assign t_r_last   = r_beat == q_len[q_head];
   assign r_pop      = t_r_valid && t_r_ready && t_r_last;

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         q_head <= '0;
         q_tail <= '0;
         q_cnt  <= '0;
         r_beat <= '0;
      end
      else
      begin
         if (ar_fire)
            q_tail <= (q_tail == r_max - 1) ? '0 : q_tail + 1'b1;
         if (r_pop)
         begin
            q_head <= (q_head == r_max - 1) ? '0 : q_head + 1'b1;
            r_beat <= '0;
         end
         else if (t_r_valid && t_r_ready)
            r_beat <= r_beat + 1'b1;
         case ({ar_fire, r_pop})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: q_cnt <= q_cnt;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (ar_fire)
      begin
         q_id[q_tail]   <= t_ar_id;
         q_addr[q_tail] <= t_ar_addr[addr_w-1:2];
         q_len[q_tail]  <= t_ar_len;
      end
   end

endmodule

// File: source/nasti_read_mux.sv
//**********************************************************
// read channel mux with R response routing
//**********************************************************
module nasti_read_mux
(
   input  logic                                               clk,
   input  logic                                               rstn,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   ar_id,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::addr_w-1:0] ar_addr,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::len_w-1:0]  ar_len,
   input  logic [nasti_pkg::n_ports-1:0]                        ar_valid,
   output logic [nasti_pkg::n_ports-1:0]                        ar_ready,
   output logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   r_id,
   output logic [nasti_pkg::n_ports-1:0][nasti_pkg::data_w-1:0] r_data,
   output logic [nasti_pkg::n_ports-1:0][1:0]                   r_resp,
   output logic [nasti_pkg::n_ports-1:0]                        r_last,
   output logic [nasti_pkg::n_ports-1:0]                        r_valid,
   input  logic [nasti_pkg::n_ports-1:0]                        r_ready,
   output logic [nasti_pkg::id_w-1:0]                           t_ar_id,
   output logic [nasti_pkg::addr_w-1:0]                         t_ar_addr,
   output logic [nasti_pkg::len_w-1:0]                          t_ar_len,
   output logic                                                 t_ar_valid,
   input  logic                                                 t_ar_ready,
   input  logic [nasti_pkg::id_w-1:0]                           t_r_id,
   input  logic [nasti_pkg::data_w-1:0]                         t_r_data,
   input  logic [1:0]                                           t_r_resp,
   input  logic                                                 t_r_last,
   input  logic                                                 t_r_valid,
   output logic                                                 t_r_ready
);
   import nasti_pkg::*;

   logic [n_ports-1:0] gnt;
   logic [port_w-1:0]  sel;
   logic               tbl_full;
   logic [port_w-1:0]  r_port;

   arbiter_rr ar_arb_i
   (
      .clk    (clk),
      .rstn   (rstn),
      .req    (ar_valid),
      .enable (!tbl_full),
      .gnt    (gnt)
   );

   always_comb
   begin
      sel = '0;
      for (int i = 0; i < n_ports; i++)
         if (gnt[i])
            sel = port_w'(i);
   end

   assign t_ar_id    = ar_id[sel];
   assign t_ar_addr  = ar_addr[sel];
   assign t_ar_len   = ar_len[sel];
   assign t_ar_valid = |gnt;
   assign ar_ready   = t_ar_ready ? gnt : '0;

   // entry lives until the last beat
   nasti_txn_table #(.depth(r_max)) rd_tbl_i
   (
      .clk        (clk),
      .rstn       (rstn),
      .alloc      (t_ar_valid && t_ar_ready),
      .alloc_id   (t_ar_id),
      .alloc_port (sel),
      .full       (tbl_full),
      .rsp_valid  (t_r_valid),
      .rsp_id     (t_r_id),
      .rsp_done   (t_r_valid && t_r_ready && t_r_last),
      .rsp_port   (r_port)
   );

   assign r_id      = {n_ports{t_r_id}};
   assign r_data    = {n_ports{t_r_data}};
   assign r_resp    = {n_ports{t_r_resp}};
   assign r_last    = {n_ports{t_r_last}};
   assign r_valid   = t_r_valid ? (n_ports'(1) << r_port) : '0;
   assign t_r_ready = t_r_valid && r_ready[r_port];

endmodule

// File: source/nasti_write_mux.sv
//**********************************************************
// write channel mux, burst lock and B response routing
//**********************************************************
module nasti_write_mux
(
   input  logic                                               clk,
   input  logic                                               rstn,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   aw_id,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::addr_w-1:0] aw_addr,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::len_w-1:0]  aw_len,
   input  logic [nasti_pkg::n_ports-1:0]                        aw_valid,
   output logic [nasti_pkg::n_ports-1:0]                        aw_ready,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::data_w-1:0] w_data,
   input  logic [nasti_pkg::n_ports-1:0][nasti_pkg::strb_w-1:0] w_strb,
   input  logic [nasti_pkg::n_ports-1:0]                        w_last,
   input  logic [nasti_pkg::n_ports-1:0]                        w_valid,
   output logic [nasti_pkg::n_ports-1:0]                        w_ready,
   output logic [nasti_pkg::n_ports-1:0][nasti_pkg::id_w-1:0]   b_id,
   output logic [nasti_pkg::n_ports-1:0][1:0]                   b_resp,
   output logic [nasti_pkg::n_ports-1:0]                        b_valid,
   input  logic [nasti_pkg::n_ports-1:0]                        b_ready,
   output logic [nasti_pkg::id_w-1:0]                           t_aw_id,
   output logic [nasti_pkg::addr_w-1:0]                         t_aw_addr,
   output logic [nasti_pkg::len_w-1:0]                          t_aw_len,
   output logic                                                 t_aw_valid,
   input  logic                                                 t_aw_ready,
   output logic [nasti_pkg::data_w-1:0]                         t_w_data,
   output logic [nasti_pkg::strb_w-1:0]                         t_w_strb,
   output logic                                                 t_w_last,
   output logic                                                 t_w_valid,
   input  logic                                                 t_w_ready,
   input  logic [nasti_pkg::id_w-1:0]                           t_b_id,
   input  logic [1:0]                                           t_b_resp,
   input  logic                                                 t_b_valid,
   output logic                                                 t_b_ready
);
   import nasti_pkg::*;

   logic [n_ports-1:0] gnt;
   logic [port_w-1:0]  gnt_port;
   logic [port_w-1:0]  sel;
   logic               lock;
   logic [port_w-1:0]  locked_port;
   logic               tbl_full;
   logic [port_w-1:0]  b_port;

   arbiter_rr aw_arb_i
   (
      .clk    (clk),
      .rstn   (rstn),
      .req    (aw_valid),
      .enable (!lock && !tbl_full),
      .gnt    (gnt)
   );

   always_comb
   begin
      gnt_port = '0;
      for (int i = 0; i < n_ports; i++)
         if (gnt[i])
            gnt_port = port_w'(i);
   end

   assign sel = lock ? locked_port : gnt_port;

   assign t_aw_id    = aw_id[sel];
   assign t_aw_addr  = aw_addr[sel];
   assign t_aw_len   = aw_len[sel];
   assign t_aw_valid = !lock && |gnt;
   assign aw_ready   = (t_aw_ready && !lock) ? gnt : '0;

   assign t_w_data  = w_data[sel];
   assign t_w_strb  = w_strb[sel];
   assign t_w_last  = w_last[sel];
   assign t_w_valid = lock && w_valid[sel];   // data only inside a burst
   assign w_ready   = (lock && t_w_ready) ? (n_ports'(1) << locked_port) : '0;

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         lock        <= 1'b0;
         locked_port <= '0;
      end
      else if (t_aw_valid && t_aw_ready)
      begin
         lock        <= 1'b1;
         locked_port <= sel;
      end
      else if (t_w_valid && t_w_ready && t_w_last)
         lock <= 1'b0;
   end

   nasti_txn_table #(.depth(w_max)) wr_tbl_i
   (
      .clk        (clk),
      .rstn       (rstn),
      .alloc      (t_aw_valid && t_aw_ready),
      .alloc_id   (t_aw_id),
      .alloc_port (sel),
      .full       (tbl_full),
      .rsp_valid  (t_b_valid),
      .rsp_id     (t_b_id),
      .rsp_done   (t_b_valid && t_b_ready),
      .rsp_port   (b_port)
   );

   // id and resp go to every port, valid only to the owner
   assign b_id      = {n_ports{t_b_id}};
   assign b_resp    = {n_ports{t_b_resp}};
   assign b_valid   = t_b_valid ? (n_ports'(1) << b_port) : '0;
   assign t_b_ready = t_b_valid && b_ready[b_port];

endmodule

// File: source/nasti_txn_table.sv
//**********************************************************
// outstanding transaction table, id and port per entry
//**********************************************************
module nasti_txn_table
#(
   parameter int depth = 2
)
(
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         alloc,
   input  logic [nasti_pkg::id_w-1:0]   alloc_id,
   input  logic [nasti_pkg::port_w-1:0] alloc_port,
   output logic                         full,
   input  logic                         rsp_valid,
   input  logic [nasti_pkg::id_w-1:0]   rsp_id,
   input  logic                         rsp_done,
   output logic [nasti_pkg::port_w-1:0] rsp_port
);
   import nasti_pkg::*;

   logic [depth-1:0]             ent_valid;
   logic [depth-1:0][id_w-1:0]   ent_id;
   logic [depth-1:0][port_w-1:0] ent_port;
   int                           free_idx;
   int                           hit_idx;
   logic                         hit;

   assign full = &ent_valid;

   // scanning downward leaves the lowest index
   always_comb
   begin
      free_idx = 0;
      for (int i = depth - 1; i >= 0; i--)
         if (!ent_valid[i])
            free_idx = i;
   end

   always_comb
   begin
      hit     = 1'b0;
      hit_idx = 0;
      for (int i = depth - 1; i >= 0; i--)
         if (rsp_valid && ent_valid[i] && ent_id[i] == rsp_id)
         begin
            hit     = 1'b1;
            hit_idx = i;
         end
   end

   assign rsp_port = hit ? ent_port[hit_idx] : '0;

   // alloc and free never touch the same slot
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         ent_valid <= '0;
      else
      begin
         if (alloc && !full)
            ent_valid[free_idx] <= 1'b1;
         if (rsp_done && hit)
            ent_valid[hit_idx] <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (alloc && !full)
      begin
         ent_id[free_idx]   <= alloc_id;
         ent_port[free_idx] <= alloc_port;
      end
   end

endmodule

// File: source/arbiter_rr.sv
//**********************************************************
// round-robin arbiter, one-hot grant with enable
//**********************************************************
module arbiter_rr
(
   input  logic                          clk,
   input  logic                          rstn,
   input  logic [nasti_pkg::n_ports-1:0] req,
   input  logic                          enable,
   output logic [nasti_pkg::n_ports-1:0] gnt
);
   import nasti_pkg::*;

   logic [port_w-1:0] last;   // last winner
   logic [port_w-1:0] win;

   // search starts one past the last winner
   always_comb
   begin
      int   idx;
      logic found;
      gnt   = '0;
      win   = last;
      found = 1'b0;
      for (int i = 1; i <= n_ports; i++)
      begin
         idx = (int'(last) + i) % n_ports;
         if (enable && !found && req[idx])
         begin
            gnt[idx] = 1'b1;
            win      = port_w'(idx);
            found    = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         last <= port_w'(n_ports - 1);   // port 0 first after reset
      else if (enable && |gnt)
         last <= win;
   end

endmodule

// File: source/nasti_pkg.sv
//**********************************************************
// nasti subsystem shared widths, depths and response codes
//**********************************************************
package nasti_pkg;

   localparam int n_ports = 4;    // initiator ports
   localparam int port_w  = 2;
   localparam int id_w    = 2;
   localparam int addr_w  = 8;    // byte address, word index in [7:2]
   localparam int data_w  = 32;
   localparam int strb_w  = 4;
   localparam int len_w   = 2;    // beats = len + 1

   // outstanding transaction tables
   localparam int w_max = 2;
   localparam int r_max = 2;

   localparam logic [1:0] resp_okay = 2'b00;

endpackage
